//--- disc_farm.f
rtl/disc_pkg.sv
rtl/arg_distributor.sv
rtl/disc_calc.sv
rtl/res_collector.sv
rtl/disc_farm_top.sv
tests/disc_farm_tb.sv

//--- rtl/arg_distributor.sv
`timescale 1ns/1ps
`default_nettype none

// round-robin dispatch of input strobes onto the calculator start lines
module arg_distributor #(
  parameter int N_UNITS = 10
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               arg_vld_i,      // operand strobe from the source
  input  logic [N_UNITS-1:0] unit_busy_i,    // per-unit busy
  output logic [N_UNITS-1:0] unit_start_o,   // strobe routed to one unit
  output logic               busy_o          // unit under the pointer still working
);

  logic [N_UNITS-1:0]   ptr_q;     // one-hot, unit that takes the next strobe
  logic [2*N_UNITS-1:0] ptr_rot;   // doubled pointer shifted by one

  // upper half of the doubled, shifted pointer is the pointer rotated by one,
  // which also holds for a single unit
  assign ptr_rot = {ptr_q, ptr_q} << 1;

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= N_UNITS'(1);                          // start at unit 0
    end else if (arg_vld_i) begin
      ptr_q <= ptr_rot[2*N_UNITS-1:N_UNITS];         // advance per accepted set
    end
  end

  assign unit_start_o = ptr_q & {N_UNITS{arg_vld_i}};  // gate strobe to pointed unit
  assign busy_o       = |(ptr_q & unit_busy_i);        // busy bit of pointed unit

  // pointer must never lose or duplicate its token
  a_ptr_onehot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot(ptr_q)
  ) else $error("arg_distributor: pointer not one-hot (%b)", ptr_q);

  // source has to hold off while the next unit is still running
  a_no_vld_when_busy: assert property (
    @(posedge clk) disable iff (rst)
    arg_vld_i |-> !busy_o
  ) else $error("arg_distributor: strobe while busy_o high");

endmodule

`default_nettype wire

//--- rtl/disc_calc.sv
`timescale 1ns/1ps
`default_nettype none

// one non-pipelined discriminant unit, b*b - 4*a*c with bit-serial multipliers
module disc_calc (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start_i,    // sample args_i and begin
  input  disc_pkg::disc_args_t args_i,
  output logic                 done_o,     // one-cycle pulse while res_o is new
  output disc_pkg::disc_res_t  res_o,      // held until the next result
  output logic                 busy_o
);

  localparam int OP_W   = disc_pkg::OP_W;
  localparam int RES_W  = disc_pkg::RES_W;
  localparam int FULL_W = disc_pkg::FULL_W;
  localparam int PROD_W = 2 * OP_W;              // unsigned product of two magnitudes
  localparam int CNT_W  = $clog2(OP_W + 1);

  logic [OP_W-1:0]     a_mag;        // input magnitudes with the signs kept aside
  logic [OP_W-1:0]     b_mag;
  logic [OP_W-1:0]     c_mag;

  logic                run_q;        // between load and combine
  logic [CNT_W-1:0]    step_q;       // multiply steps done
  logic                done_q;
  logic                combine;      // last cycle of the operation

  logic [PROD_W-1:0]   bb_acc_q;     // partial |b|*|b|
  logic [PROD_W-1:0]   bb_mcand_q;   // |b| moving left one bit per step
  logic [OP_W-1:0]     bb_mplier_q;  // |b| moving right one bit per step
  logic [PROD_W-1:0]   ac_acc_q;     // partial |a|*|c|
  logic [PROD_W-1:0]   ac_mcand_q;
  logic [OP_W-1:0]     ac_mplier_q;
  logic                ac_neg_q;     // sign of a*c

  logic [FULL_W-1:0]   bb_ext;
  logic [FULL_W-1:0]   ac4_ext;      // 4*|a*c|
  logic [FULL_W-1:0]   full;         // exact discriminant in two's complement
  disc_pkg::disc_res_t res_d;
  disc_pkg::disc_res_t res_q;

  // one shift-add step adds the shifted multiplicand when the multiplier bit is set
  function automatic logic [PROD_W-1:0] mac_step(input logic [PROD_W-1:0] acc,
                                                 input logic [PROD_W-1:0] mcand,
                                                 input logic              bit_i);
    return bit_i ? acc + mcand : acc;
  endfunction

  assign a_mag = args_i.a[OP_W-1] ? -args_i.a : args_i.a;   // -128 gives 8'h80
  assign b_mag = args_i.b[OP_W-1] ? -args_i.b : args_i.b;
  assign c_mag = args_i.c[OP_W-1] ? -args_i.c : args_i.c;

  assign combine = run_q && (step_q == CNT_W'(OP_W));

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q  <= 1'b0;
      step_q <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;                       // pulse only
      if (start_i) begin                    // load cycle
        run_q  <= 1'b1;
        step_q <= '0;
      end else if (combine) begin
        run_q  <= 1'b0;
        done_q <= 1'b1;
      end else if (run_q) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (start_i) begin
      bb_acc_q    <= '0;
      bb_mcand_q  <= PROD_W'(b_mag);
      bb_mplier_q <= b_mag;
      ac_acc_q    <= '0;
      ac_mcand_q  <= PROD_W'(a_mag);
      ac_mplier_q <= c_mag;
      ac_neg_q    <= args_i.a[OP_W-1] ^ args_i.c[OP_W-1];
    end else if (run_q && !combine) begin
      bb_acc_q    <= mac_step(bb_acc_q, bb_mcand_q, bb_mplier_q[0]);
      bb_mcand_q  <= bb_mcand_q << 1;
      bb_mplier_q <= bb_mplier_q >> 1;
      ac_acc_q    <= mac_step(ac_acc_q, ac_mcand_q, ac_mplier_q[0]);
      ac_mcand_q  <= ac_mcand_q << 1;
      ac_mplier_q <= ac_mplier_q >> 1;
    end
    if (combine) begin
      res_q <= res_d;
    end
  end

  // b*b is never negative, so only the sign of a*c picks add or subtract
  assign bb_ext  = FULL_W'(bb_acc_q);
  assign ac4_ext = FULL_W'({ac_acc_q, 2'b00});
  assign full    = ac_neg_q ? bb_ext + ac4_ext : bb_ext - ac4_ext;

  always_comb begin
    res_d.value    = full[RES_W-1:0];                      // truncated value
    res_d.negative = full[FULL_W-1];                       // exact sign
    // overflow when the dropped bits are not copies of bit RES_W-1
    res_d.err      = full[FULL_W-1:RES_W-1] != {(FULL_W-RES_W+1){full[RES_W-1]}};
  end

  assign done_o = done_q;
  assign res_o  = res_q;
  assign busy_o = run_q;

  a_no_start_when_busy: assert property (
    @(posedge clk) disable iff (rst)
    start_i |-> !busy_o
  ) else $error("disc_calc: start while busy");

  // collector relies on the fixed latency, done_o is seen CALC_LAT edges after start
  a_fixed_latency: assert property (
    @(posedge clk) disable iff (rst)
    start_i |-> ##(disc_pkg::CALC_LAT) done_o
  ) else $error("disc_calc: result not on time");

endmodule

`default_nettype wire

//--- rtl/disc_farm_top.sv
`timescale 1ns/1ps
`default_nettype none

// farm of N_UNITS slow discriminant units behind a round-robin dispatcher
module disc_farm_top #(
  parameter int N_UNITS = disc_pkg::CALC_LAT    // CALC_LAT units give one set per cycle
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 arg_vld_i,   // one-cycle strobe, args_i sampled with it
  input  disc_pkg::disc_args_t args_i,
  output logic                 res_vld_o,   // one-cycle strobe
  output disc_pkg::disc_res_t  res_o,
  output logic                 busy_o       // source holds off while high
);

  logic [N_UNITS-1:0]                unit_start;   // per-unit start strobe
  logic [N_UNITS-1:0]                unit_busy;
  logic [N_UNITS-1:0]                unit_done;
  disc_pkg::disc_res_t [N_UNITS-1:0] unit_res;

  // more units than CALC_LAT would never be used, none would never work
  if (N_UNITS < 1 || N_UNITS > disc_pkg::CALC_LAT) begin : g_bad_units
    $error("disc_farm_top: N_UNITS must lie in 1..CALC_LAT");
  end

  arg_distributor #(
    .N_UNITS (N_UNITS)
  ) i_distributor (
    .clk          (clk),
    .rst          (rst),
    .arg_vld_i    (arg_vld_i),
    .unit_busy_i  (unit_busy),
    .unit_start_o (unit_start),
    .busy_o       (busy_o)
  );

  // identical calculators, all see the same operands
  for (genvar i = 0; i < N_UNITS; i++) begin : g_unit
    disc_calc i_calc (
      .clk     (clk),
      .rst     (rst),
      .start_i (unit_start[i]),
      .args_i  (args_i),
      .done_o  (unit_done[i]),
      .res_o   (unit_res[i]),
      .busy_o  (unit_busy[i])
    );
  end

  res_collector #(
    .N_UNITS (N_UNITS)
  ) i_collector (
    .clk         (clk),
    .rst         (rst),
    .arg_vld_i   (arg_vld_i),     // source never strobes while busy, so every strobe is taken
    .unit_done_i (unit_done),
    .unit_res_i  (unit_res),
    .res_vld_o   (res_vld_o),
    .res_o       (res_o)
  );

endmodule

`default_nettype wire

//--- rtl/disc_pkg.sv
`default_nettype none

// shared widths, latency and payload types of the discriminant farm
package disc_pkg;

  localparam int OP_W   = 8;               // signed coefficient width
  localparam int RES_W  = 16;              // width of the value at the farm output
  localparam int FULL_W = 2 * OP_W + 3;    // b*b - 4*a*c always fits here

  // one load cycle, one multiply step per operand bit, one combine cycle
  localparam int CALC_LAT = OP_W + 2;

  // one operand set, sampled together with the input strobe
  typedef struct packed {
    logic signed [OP_W-1:0] a;
    logic signed [OP_W-1:0] b;
    logic signed [OP_W-1:0] c;
  } disc_args_t;

  // result of one calculator
  typedef struct packed {
    logic [RES_W-1:0] value;     // low RES_W bits of the exact discriminant
    logic             negative;  // exact result below zero
    logic             err;       // exact result outside the signed RES_W range
  } disc_res_t;

endpackage

`default_nettype wire

//--- rtl/res_collector.sv
`timescale 1ns/1ps
`default_nettype none

// strobe delay line plus round-robin drain of the unit results
module res_collector #(
  parameter int N_UNITS = 10
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              arg_vld_i,     // accepted input strobe
  input  logic [N_UNITS-1:0]                unit_done_i,
  input  disc_pkg::disc_res_t [N_UNITS-1:0] unit_res_i,
  output logic                              res_vld_o,
  output disc_pkg::disc_res_t               res_o
);

  localparam int LAT   = disc_pkg::CALC_LAT;
  localparam int SEL_W = (N_UNITS > 1) ? $clog2(N_UNITS) : 1;

  logic [LAT-1:0]   vld_dly_q;   // strobe travelling alongside the calculation
  logic [SEL_W-1:0] sel_q;       // unit whose result drains next
  logic             sel_last;

  assign sel_last = (sel_q == SEL_W'(N_UNITS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_dly_q <= '0;
      sel_q     <= '0;
    end else begin
      vld_dly_q <= {vld_dly_q[LAT-2:0], arg_vld_i};
      if (res_vld_o) begin
        sel_q <= sel_last ? '0 : sel_q + 1'b1;   // wrap after the last unit
      end
    end
  end

  // last stage is the output strobe, exactly LAT cycles after acceptance
  assign res_vld_o = vld_dly_q[LAT-1];

  // units finish in the order they were started, so the selector tracks them
  assign res_o = unit_res_i[sel_q];

  // delay line and calculator must agree on which unit is finishing
  a_sel_done: assert property (
    @(posedge clk) disable iff (rst)
    res_vld_o |-> unit_done_i[sel_q]
  ) else $error("res_collector: unit %0d not done at output strobe", sel_q);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build the discriminant farm testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module disc_farm_tb -f disc_farm.f -o sim_disc_farm \
  && ./obj_dir/sim_disc_farm | tee /dev/stderr | grep -q '^>>> PASS$' \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

//--- tests/disc_farm_tb.sv
`timescale 1ns/1ps
`default_nettype none

// random-stimulus testbench for the discriminant farm, checked against an exact model
module disc_farm_tb;

  localparam int N_UNITS         = 8;                    // below CALC_LAT so busy_o shows up
  localparam int CALC_LAT        = disc_pkg::CALC_LAT;
  localparam int OP_W            = disc_pkg::OP_W;
  localparam int RES_W           = disc_pkg::RES_W;
  localparam int CLK_PERIOD      = 40;
  localparam int RST_CYCLES      = 5;
  localparam int N_RANDOM        = 150;                  // sets issued on a random request bit
  localparam int N_SETS          = 300;                  // the rest go out as a burst
  localparam int WATCHDOG_CYCLES = (N_SETS + 50) * CALC_LAT;
  localparam int RES_MAX         = (1 << (RES_W - 1)) - 1;
  localparam int RES_MIN         = -(1 << (RES_W - 1));

  logic                 clk;
  logic                 rst;
  logic                 arg_vld_i;
  disc_pkg::disc_args_t args_i;
  logic                 res_vld_o;
  disc_pkg::disc_res_t  res_o;
  logic                 busy_o;

  logic [31:0] lfsr_q;             // random source state
  int          edge_no;            // rising edges seen so far
  int          issued;
  int          checked;
  int          errors;
  int          busy_seen;          // cycles with busy_o high
  int          acc_edge[N_SETS];   // edge that sampled each issued set
  int          exp_disc_q[$];      // exact discriminants still in flight
  int          exp_edge_q[$];      // their acceptance edges

  disc_farm_top #(
    .N_UNITS (N_UNITS)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .arg_vld_i (arg_vld_i),
    .args_i    (args_i),
    .res_vld_o (res_vld_o),
    .res_o     (res_o),
    .busy_o    (busy_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Galois LFSR shifting right with taps 32'h80200003
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit handed out with the first bit ending up as the msb
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return r;
  endfunction

  // exact b*b - 4*a*c in plain integers
  function automatic int exact_disc(input disc_pkg::disc_args_t s);
    int a;
    int b;
    int c;
    a = $signed(s.a);
    b = $signed(s.b);
    c = $signed(s.c);
    return b * b - 4 * a * c;
  endfunction

  task automatic wait_edge();
    @(posedge clk);
    #1;                                          // outputs have settled and inputs may change
    edge_no++;
  endtask

  task automatic check_result(input int disc, input int acc);
    logic [RES_W-1:0] exp_val;
    logic             exp_neg;
    logic             exp_err;
    exp_val = disc[RES_W-1:0];                   // truncated two's complement
    exp_neg = (disc < 0);
    exp_err = (disc > RES_MAX) || (disc < RES_MIN);
    // strobe is visible in the cycle after edge acc + CALC_LAT - 1
    if (edge_no - acc != CALC_LAT - 1) begin
      $display("result for the set accepted at edge %0d came %0d edges later instead of %0d",
               acc, edge_no - acc, CALC_LAT - 1);
      errors++;
    end
    if (res_o.value !== exp_val) begin
      $display("Error: res_o.value = %h, expected %h (edge %0d)", res_o.value, exp_val, edge_no);
      errors++;
    end
    if (res_o.negative !== exp_neg) begin
      $display("Error: res_o.negative = %h, expected %h (edge %0d)",
               res_o.negative, exp_neg, edge_no);
      errors++;
    end
    if (res_o.err !== exp_err) begin
      $display("Error: res_o.err = %h, expected %h (edge %0d)", res_o.err, exp_err, edge_no);
      errors++;
    end
    checked++;
  endtask

  task automatic check_outputs();
    logic exp_busy;
    int   disc;
    int   acc;
    exp_busy = 1'b0;
    // unit under the pointer last took set issued-N_UNITS and stays busy until its result edge
    if (issued >= N_UNITS) begin
      exp_busy = (edge_no - acc_edge[issued - N_UNITS]) < CALC_LAT - 1;
    end
    if (busy_o !== exp_busy) begin
      $display("Error: busy_o = %h, expected %h (edge %0d)", busy_o, exp_busy, edge_no);
      errors++;
    end
    if (busy_o === 1'b1) busy_seen++;
    if (res_vld_o === 1'b1) begin
      if (exp_disc_q.size() == 0) begin
        $display("result strobe at edge %0d with no set outstanding", edge_no);
        errors++;
      end else begin
        disc = exp_disc_q.pop_front();
        acc  = exp_edge_q.pop_front();
        check_result(disc, acc);
      end
    end else if (exp_edge_q.size() > 0 && edge_no - exp_edge_q[0] >= CALC_LAT - 1) begin
      $display("no result strobe for the set accepted at edge %0d", exp_edge_q[0]);
      errors++;
      disc = exp_disc_q.pop_front();             // drop it so later sets line up again
      acc  = exp_edge_q.pop_front();
    end
  endtask

  // check the DUT outputs of this cycle and then drive the next request
  task automatic run_cycle(input logic want);
    logic [31:0]          r;
    disc_pkg::disc_args_t s;
    wait_edge();
    check_outputs();
    arg_vld_i = 1'b0;
    if (want && !busy_o && issued < N_SETS) begin
      r         = take_bits(3 * OP_W);
      s         = r[3*OP_W-1:0];
      args_i    = s;
      arg_vld_i = 1'b1;
      acc_edge[issued] = edge_no + 1;            // sampled on the coming edge
      exp_disc_q.push_back(exact_disc(s));
      exp_edge_q.push_back(edge_no + 1);
      issued++;
    end
  endtask

  initial begin
    logic [31:0] r;
    lfsr_q    = 32'hd2e9525e;
    rst       = 1'b1;
    arg_vld_i = 1'b0;
    args_i    = '0;
    edge_no   = 0;
    issued    = 0;
    checked   = 0;
    errors    = 0;
    busy_seen = 0;

    repeat (RST_CYCLES) begin
      wait_edge();
      if (res_vld_o !== 1'b0) begin
        $display("Error: res_vld_o = %h, expected 0 during reset", res_vld_o);
        errors++;
      end
      if (busy_o !== 1'b0) begin
        $display("Error: busy_o = %h, expected 0 during reset", busy_o);
        errors++;
      end
    end
    rst = 1'b0;

    while (issued < N_RANDOM) begin              // random request pattern
      r = take_bits(1);
      run_cycle(r[0]);
    end
    while (issued < N_SETS) begin                // burst phase keeps consuming the request bit
      r = take_bits(1);
      run_cycle(1'b1);
    end
    repeat (CALC_LAT + 2) run_cycle(1'b0);       // drain while stray strobes are still caught

    if (exp_disc_q.size() != 0) begin
      $display("%0d sets never produced a result", exp_disc_q.size());
      errors++;
    end
    if (busy_seen == 0) begin
      $display("busy_o never went high during the burst");
      errors++;
    end

    $display("errors: %0d, results checked: %0d of %0d issued", errors, checked, issued);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // run cannot outlive the worst-case length of the tests
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles with %0d of %0d sets issued",
             WATCHDOG_CYCLES, issued, N_SETS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire
